// File: act_cfg.svh
`ifndef ACT_CFG_SVH
`define ACT_CFG_SVH

// Width of one result word from the systolic array
`define ACT_DWIDTH 8

// Columns of the array, one activation lane per column
`define ACT_LANES 8

// One mask bit per lane
`define ACT_MASK_WIDTH `ACT_LANES

// Rows in one matrix before done is raised
`define ACT_ROWS 8

`endif

// File: act_pkg.sv
`include "act_cfg.svh"

package act_pkg;

  // Selected by activation_type
  typedef enum logic {
    ACT_RELU = 1'b0,
    ACT_TANH = 1'b1
  } act_func_e;

  typedef logic signed [`ACT_DWIDTH-1:0] act_data_t;

  typedef struct packed {
    act_func_e func;
    logic      enable;
  } act_ctrl_t;

  // Lane 0 sits in the low word
  typedef struct packed {
    act_data_t [`ACT_LANES-1:0] word;
  } act_row_t;

endpackage

// File: act_strobe_skew.sv
`timescale 1ns/1ps

`include "act_cfg.svh"

module act_strobe_skew import act_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  activation_type,
  input  logic                  enable_activation,
  input  logic                  in_data_available,
  output act_ctrl_t             ctrl,
  output logic [`ACT_LANES-1:0] lane_strobe
);

  // Delayed copies of the row strobe for lanes 1 and up
  logic [`ACT_LANES-1:1] skew_q;

  always_comb begin
    ctrl.func   = act_func_e'(activation_type);
    ctrl.enable = enable_activation;
  end

  // Lane i sees its word i cycles after the row strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      skew_q <= '0;
    end else begin
      skew_q[1] <= in_data_available;
      for (int i = 2; i < `ACT_LANES; i++) begin
        skew_q[i] <= skew_q[i-1];
      end
    end
  end

  assign lane_strobe = {skew_q, in_data_available};

endmodule

// File: act_lane.sv
`timescale 1ns/1ps

`include "act_cfg.svh"

module act_lane import act_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  act_ctrl_t ctrl,
  input  logic      in_strobe,
  input  act_data_t inp_data,
  input  logic      mask,
  output act_data_t out_data,
  output logic      out_strobe
);

  localparam int PW = 2 * `ACT_DWIDTH;

  act_data_t            seg_slope;
  act_data_t            seg_intercept;
  logic                 is_tanh;
  logic                 load_result;

  logic                 s1_q;
  logic                 s2_q;
  logic                 s3_q;

  act_data_t            relu_q;
  logic signed [PW-1:0] product_q;
  act_data_t            intercept_q;
  logic signed [PW-1:0] sum_q;
  act_data_t            result_q;

  assign is_tanh = (ctrl.func == ACT_TANH);

  // Piecewise-linear tanh, y = slope * x + intercept
  always_comb begin
    if (inp_data >= 90) begin
      seg_slope     = act_data_t'(0);
      seg_intercept = act_data_t'(127);
    end else if (inp_data >= 39) begin
      seg_slope     = act_data_t'(0);
      seg_intercept = act_data_t'(99);
    end else if (inp_data >= 28) begin
      seg_slope     = act_data_t'(2);
      seg_intercept = act_data_t'(46);
    end else if (inp_data >= 16) begin
      seg_slope     = act_data_t'(3);
      seg_intercept = act_data_t'(18);
    end else if (inp_data >= 1) begin
      seg_slope     = act_data_t'(4);
      seg_intercept = act_data_t'(0);
    end else if (inp_data == 0) begin
      seg_slope     = act_data_t'(0);
      seg_intercept = act_data_t'(0);
    end else if (inp_data >= -15) begin
      seg_slope     = act_data_t'(4);
      seg_intercept = act_data_t'(0);
    end else if (inp_data >= -27) begin
      seg_slope     = act_data_t'(3);
      seg_intercept = act_data_t'(-18);
    end else if (inp_data >= -38) begin
      seg_slope     = act_data_t'(2);
      seg_intercept = act_data_t'(-46);
    end else if (inp_data >= -89) begin
      seg_slope     = act_data_t'(0);
      seg_intercept = act_data_t'(-99);
    end else begin
      seg_slope     = act_data_t'(0);
      seg_intercept = act_data_t'(-127);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_q <= 1'b0;
      s2_q <= 1'b0;
      s3_q <= 1'b0;
    end else begin
      s1_q <= in_strobe & ctrl.enable;
      s2_q <= s1_q;
      s3_q <= s2_q;
    end
  end

  // ReLU is ready after stage 1, tanh needs the extra add stage
  assign load_result = is_tanh ? s2_q : s1_q;

  always_ff @(posedge clk) begin
    if (in_strobe) begin
      relu_q      <= inp_data[`ACT_DWIDTH-1] ? '0 : inp_data;
      product_q   <= seg_slope * inp_data;
      intercept_q <= seg_intercept;
    end
    if (s1_q) begin
      sum_q <= product_q + intercept_q;
    end
    if (load_result) begin
      if (!mask) begin
        result_q <= '0;
      end else if (is_tanh) begin
        result_q <= sum_q[`ACT_DWIDTH-1:0];
      end else begin
        result_q <= relu_q;
      end
    end
  end

  // Disabled lanes forward the array output untouched
  assign out_data   = ctrl.enable ? result_q : inp_data;
  assign out_strobe = ctrl.enable ? (is_tanh ? s3_q : s2_q) : in_strobe;

endmodule

// File: act_batch_tracker.sv
`timescale 1ns/1ps

`include "act_cfg.svh"

module act_batch_tracker (
  input  logic clk,
  input  logic reset,
  input  logic last_lane_strobe,
  output logic done_activation
);

  localparam int CNT_W = (`ACT_ROWS > 1) ? $clog2(`ACT_ROWS) : 1;

  // Rows already delivered by the last lane in this batch
  logic [CNT_W-1:0] row_cnt;
  logic             batch_end;

  assign batch_end = last_lane_strobe && (row_cnt == CNT_W'(`ACT_ROWS - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      row_cnt         <= '0;
      done_activation <= 1'b0;
    end else begin
      done_activation <= batch_end;
      if (batch_end) begin
        row_cnt <= '0;
      end else if (last_lane_strobe) begin
        row_cnt <= row_cnt + 1'b1;
      end
    end
  end

endmodule

// File: activation_top.sv
`timescale 1ns/1ps

`include "act_cfg.svh"

module activation_top import act_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       activation_type,
  input  logic                       enable_activation,
  input  logic                       in_data_available,
  input  act_row_t                   inp_row,
  input  logic [`ACT_MASK_WIDTH-1:0] validity_mask,
  output act_row_t                   out_row,
  output logic                       out_data_available,
  output logic                       done_activation
);

  act_ctrl_t                  ctrl;
  logic [`ACT_LANES-1:0]      lane_strobe;
  wire  [`ACT_LANES-1:0]      out_strobe;
  wire  act_data_t [`ACT_LANES-1:0] lane_data;

  act_strobe_skew act_strobe_skew_inst (
    .clk               (clk),
    .reset             (reset),
    .activation_type   (activation_type),
    .enable_activation (enable_activation),
    .in_data_available (in_data_available),
    .ctrl              (ctrl),
    .lane_strobe       (lane_strobe)
  );

  for (genvar i = 0; i < `ACT_LANES; i++) begin : g_lane
    act_lane act_lane_inst (
      .clk        (clk),
      .reset      (reset),
      .ctrl       (ctrl),
      .in_strobe  (lane_strobe[i]),
      .inp_data   (inp_row.word[i]),
      .mask       (validity_mask[i]),
      .out_data   (lane_data[i]),
      .out_strobe (out_strobe[i])
    );
  end

  assign out_row.word       = lane_data;
  assign out_data_available = out_strobe[0];

  // A batch ends when the last column has delivered its final row
  act_batch_tracker act_batch_tracker_inst (
    .clk              (clk),
    .reset            (reset),
    .last_lane_strobe (out_strobe[`ACT_LANES-1]),
    .done_activation  (done_activation)
  );

endmodule

// File: act_assertions.sv
`timescale 1ns/1ps

`include "act_cfg.svh"

module act_assertions import act_pkg::*; (
  input logic     clk,
  input logic     reset,
  input logic     out_data_available,
  input logic     done_activation,
  input act_row_t out_row
);

  // Batch end is a single-cycle pulse
  done_one_cycle: assert property (@(posedge clk) disable iff (reset)
    done_activation |=> !done_activation)
    else $error("done_activation stayed high for two cycles");

  strobe_low_after_reset: assert property (@(posedge clk)
    reset |=> !out_data_available)
    else $error("out_data_available high in the cycle after reset");

  // Lane 0's word is the one aligned with out_data_available
  row_known: assert property (@(posedge clk) disable iff (reset)
    out_data_available |-> !$isunknown(out_row.word[0]))
    else $error("out_row has unknown bits while out_data_available is high");

endmodule

bind activation_top act_assertions act_assertions_inst (.*);

// File: tb_activation.sv
`timescale 1ns/1ps

`include "act_cfg.svh"

module tb_activation import act_pkg::*; ();

  localparam int LANES        = `ACT_LANES;
  localparam int ROWS         = `ACT_ROWS;
  localparam int SEED         = 14463;
  localparam int IDLE_TIMEOUT = 50;

  // The first lower bound that x reaches picks the tanh segment
  localparam int SEG_LO [11] = '{90, 39, 28, 16, 1, 0, -15, -27, -38, -89, -128};
  localparam int SEG_M  [11] = '{0, 0, 2, 3, 4, 0, 4, 3, 2, 0, 0};
  localparam int SEG_B  [11] = '{127, 99, 46, 18, 0, 0, 0, -18, -46, -99, -127};

  logic                       clk;
  logic                       reset;
  logic                       activation_type;
  logic                       enable_activation;
  logic                       in_data_available;
  act_row_t                   inp_row;
  logic [`ACT_MASK_WIDTH-1:0] validity_mask;
  act_row_t                   out_row;
  logic                       out_data_available;
  logic                       done_activation;

  act_data_t stim [ROWS][LANES];
  int        check_errors;
  int        timeout_errors;
  // Lane 7 strobes seen by the model since the last done
  int        model_cnt;
  bit        done_pending;

  activation_top activation_top_inst (
    .clk                (clk),
    .reset              (reset),
    .activation_type    (activation_type),
    .enable_activation  (enable_activation),
    .in_data_available  (in_data_available),
    .inp_row            (inp_row),
    .validity_mask      (validity_mask),
    .out_row            (out_row),
    .out_data_available (out_data_available),
    .done_activation    (done_activation)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic act_data_t tanh_ref(input act_data_t x);
    int xi;
    xi = int'(x);
    for (int k = 0; k < 11; k++) begin
      if (xi >= SEG_LO[k]) begin
        return act_data_t'(SEG_M[k] * xi + SEG_B[k]);
      end
    end
    return '0;
  endfunction

  function automatic act_data_t expected_word(input act_func_e func, input bit enable,
                                              input bit mask_bit, input act_data_t x);
    if (!enable) begin
      return x;
    end
    if (!mask_bit) begin
      return '0;
    end
    if (func == ACT_TANH) begin
      return tanh_ref(x);
    end
    return (int'(x) < 0) ? act_data_t'(0) : x;
  endfunction

  task automatic report_value(input string sig, input logic signed [31:0] expected,
                              input logic signed [31:0] actual);
    $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, sig, expected, actual);
    check_errors++;
  endtask

  task automatic fill_random_rows();
    for (int r = 0; r < ROWS; r++) begin
      for (int i = 0; i < LANES; i++) begin
        stim[r][i] = act_data_t'($urandom);
      end
    end
  endtask

  // Sampled on falling edges so registered outputs have settled
  task automatic wait_idle();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while ((out_data_available !== 1'b0 || done_activation !== 1'b0) &&
           cycles < IDLE_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (cycles >= IDLE_TIMEOUT) begin
      $display("Timeout: outputs did not go idle within %0d cycles at %0t",
               IDLE_TIMEOUT, $time);
      timeout_errors++;
    end
  endtask

  // Row r strobes at cycle r*stride, lane i takes its word i cycles later
  task automatic send_rows(input act_func_e func, input bit enable,
                           input logic [`ACT_MASK_WIDTH-1:0] mask, input int nrows,
                           input int stride, output int done_count);
    int        lat;
    int        last_cycle;
    int        start;
    bit        strobe_now;
    bit        avail_exp;
    bit        lane7_exp;
    bit        done_exp;
    act_data_t exp_word;
    act_row_t  row_now;
    lat        = !enable ? 0 : ((func == ACT_TANH) ? 3 : 2);
    last_cycle = (nrows - 1) * stride + LANES - 1 + lat + 2;
    done_count = 0;
    wait_idle();
    @(posedge clk);
    activation_type   <= func;
    enable_activation <= enable;
    validity_mask     <= mask;
    in_data_available <= 1'b0;
    @(posedge clk);
    for (int c = 0; c <= last_cycle; c++) begin
      strobe_now = 1'b0;
      for (int i = 0; i < LANES; i++) begin
        row_now.word[i] = act_data_t'($urandom);
      end
      for (int r = 0; r < nrows; r++) begin
        start = r * stride;
        if (start == c) begin
          strobe_now = 1'b1;
        end
        for (int i = 0; i < LANES; i++) begin
          if (start + i == c) begin
            row_now.word[i] = stim[r][i];
          end
        end
      end
      in_data_available <= strobe_now;
      inp_row           <= row_now;
      @(negedge clk);
      avail_exp    = 1'b0;
      lane7_exp    = 1'b0;
      done_exp     = done_pending;
      done_pending = 1'b0;
      for (int r = 0; r < nrows; r++) begin
        start = r * stride;
        if (start + lat == c) begin
          avail_exp = 1'b1;
        end
        if (start + LANES - 1 + lat == c) begin
          lane7_exp = 1'b1;
        end
        for (int i = 0; i < LANES; i++) begin
          if (start + i + lat == c) begin
            exp_word = expected_word(func, enable, mask[i], stim[r][i]);
            if (out_row.word[i] !== exp_word) begin
              report_value($sformatf("out_row.word[%0d]", i), exp_word, out_row.word[i]);
            end
          end
        end
      end
      if (out_data_available !== avail_exp) begin
        report_value("out_data_available", avail_exp, out_data_available);
      end
      if (lane7_exp) begin
        model_cnt++;
        if (model_cnt == ROWS) begin
          model_cnt    = 0;
          done_pending = 1'b1;
        end
      end
      if (done_activation !== done_exp) begin
        report_value("done_activation", done_exp, done_activation);
      end
      if (done_activation === 1'b1) begin
        done_count++;
      end
      @(posedge clk);
    end
  endtask

  task automatic test_relu();
    int dc;
    fill_random_rows();
    send_rows(ACT_RELU, 1'b1, '1, ROWS, 2, dc);
  endtask

  task automatic test_tanh();
    int bounds [21];
    int dc;
    bounds = '{90, 89, 39, 38, 28, 27, 16, 15, 1, 0, -1, -15, -16, -27, -28, -38, -39,
               -89, -90, 127, -128};
    fill_random_rows();
    for (int k = 0; k < 21; k++) begin
      stim[k / LANES][k % LANES] = act_data_t'(bounds[k]);
    end
    send_rows(ACT_TANH, 1'b1, '1, ROWS, 2, dc);
  endtask

  task automatic test_bypass();
    int dc;
    fill_random_rows();
    send_rows(ACT_TANH, 1'b0, `ACT_MASK_WIDTH'($urandom), ROWS, 2, dc);
  endtask

  task automatic test_mask();
    int dc;
    fill_random_rows();
    send_rows(ACT_RELU, 1'b1, `ACT_MASK_WIDTH'('b1010_0110), ROWS, 1, dc);
    fill_random_rows();
    send_rows(ACT_TANH, 1'b1, `ACT_MASK_WIDTH'('b0101_1001), ROWS, 1, dc);
  endtask

  task automatic test_back_to_back();
    int dc;
    for (int b = 0; b < 2; b++) begin
      fill_random_rows();
      send_rows((b == 0) ? ACT_RELU : ACT_TANH, 1'b1, '1, ROWS, 1, dc);
      if (dc != 1) begin
        $display("Batch %0d raised done_activation %0d times instead of once", b, dc);
        check_errors++;
      end
    end
  endtask

  initial begin
    void'($urandom(SEED));
    check_errors      = 0;
    timeout_errors    = 0;
    model_cnt         = 0;
    done_pending      = 1'b0;
    reset             = 1'b1;
    activation_type   = 1'b0;
    // Enabled during reset so out_data_available comes from the pipeline strobes
    enable_activation = 1'b1;
    in_data_available = 1'b0;
    inp_row           = '0;
    validity_mask     = '1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    test_relu();
    test_tanh();
    test_bypass();
    test_mask();
    test_back_to_back();
    $display("Check errors: %0d, timeouts: %0d", check_errors, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+.
act_pkg.sv
act_strobe_skew.sv
act_lane.sv
act_batch_tracker.sv
activation_top.sv
act_assertions.sv
tb_activation.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the activation testbench with Verilator
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal --top-module tb_activation -f filelist.f &&
  ./obj_dir/Vtb_activation | tee /dev/stderr | grep -q "SIMULATION PASSED" &&
  echo "run_sim: passed" ||
  { echo "run_sim: failed"; exit 1; }
